/* verilog.f */
verilog/sonar_pkg.sv
verilog/sonar_regs_pkg.sv
verilog/listen_if.sv
verilog/impulse_gen.sv
verilog/energy_window.sv
verilog/transient_detector.sv
verilog/sonar_ctrl.sv
verilog/apb_regs.sv
verilog/sonar_top.sv
sim/sonar_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build sonar_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module sonar_tb -f verilog.f -o sonar_sim
	./obj_dir/sonar_sim | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim/sonar_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sonar_tb;
	import sonar_pkg::*;
	import sonar_regs_pkg::*;

	localparam int MAX_CYCLES = 60000;   // several times the longest expected run
	localparam int NO_ECHO = 100000;     // echo start beyond any listening window
	localparam sample_t ECHO_AMP = 16'sd4000;

	logic clk_in;
	logic rst_in;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic step_in;
	sample_t mic_in;
	sample_t amp_out;
	logic done_irq;

	logic [31:0] seed = 32'h8612_11a2;
	sample_t noise;
	int echo_q[$];          // echo start sample of each shot in a test
	int shot_base = 0;      // impulse count when the current test started
	int impulses = 0;
	int nz_cnt = 0;         // nonzero steps seen in the current impulse
	int samp_no = 0;        // samples consumed since the impulse ended
	int echo_start = NO_ECHO;
	bit listening = 1'b0;
	bit after_pulse = 1'b0;
	sample_t expected_amp;
	int cycles = 0;
	int reg_errs = 0;
	int shape_errs = 0;
	int amp_errs = 0;
	int bus_errs = 0;

	sonar_top UUT (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// onset is reported at the end of the first window holding the echo
	function automatic logic [31:0] expected_delay(input int start);
		return 32'(((start - 1) / WINDOW_LEN + 1) * WINDOW_LEN);
	endfunction

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;
	end

	// a step every 4 cycles with its own mic sample
	initial begin
		step_in = 1'b0;
		mic_in = '0;
		forever begin
			@(posedge clk_in);
			#2;
			step_in = 1'b1;
			if (listening && samp_no + 1 >= echo_start) begin
				mic_in = ECHO_AMP;
			end else begin
				seed = lcg_next(seed);
				noise = sample_t'(2 + seed[16]);   // magnitude 2 or 3
				mic_in = seed[20] ? -noise : noise;
			end
			@(posedge clk_in);
			#2;
			step_in = 1'b0;
			repeat (2) @(posedge clk_in);
		end
	end

	// echo model and impulse shape check at mid-cycle
	always @(negedge clk_in) begin
		if (!rst_in && step_in) begin
			if (after_pulse)
				assert (amp_out == '0) else begin
					shape_errs++;
					$display("ERR %0t: impulse longer than %0d steps", $time, PULSE_LEN);
				end
			after_pulse = 1'b0;
			if (amp_out != '0) begin
				expected_amp = (nz_cnt < PULSE_LEN / 2) ? PULSE_AMP : sample_t'(-PULSE_AMP);
				assert (amp_out == expected_amp) else begin
					shape_errs++;
					$display("ERR %0t: impulse step %0d is %0d, expected %0d",
						$time, nz_cnt, amp_out, expected_amp);
				end
				nz_cnt++;
				if (nz_cnt == PULSE_LEN) begin   // next step is sample 1
					nz_cnt = 0;
					samp_no = 0;
					listening = 1'b1;
					after_pulse = 1'b1;
					echo_start = (impulses - shot_base < echo_q.size()) ?
						echo_q[impulses - shot_base] : NO_ECHO;
					impulses++;
				end
			end else begin
				assert (nz_cnt == 0) else begin
					shape_errs++;
					$display("ERR %0t: impulse cut short after %0d steps", $time, nz_cnt);
				end
				if (listening)
					samp_no++;
			end
		end
	end

	bus_ok: assert property (@(posedge clk_in) pready && !pslverr) else begin
		bus_errs++;
		$display("ERR %0t: pready low or pslverr high", $time);
	end

	amp_idle: assert property (@(posedge clk_in) disable iff (rst_in)
		(amp_out != '0) |-> UUT.busy) else begin
		amp_errs++;
		$display("ERR %0t: amp_out is %0d while idle", $time, amp_out);
	end

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		@(posedge clk_in);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk_in);
		#2;
		penable = 1'b1;
		@(posedge clk_in);   // access edge
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
		@(posedge clk_in);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk_in);
		#2;
		penable = 1'b1;
		@(negedge clk_in);
		data = prdata;
		@(posedge clk_in);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_reg(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] got;
		apb_read(addr, got);
		assert (got == exp) else begin
			reg_errs++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// start a run and poll status until busy drops
	task automatic start_and_wait;
		logic [31:0] status;
		shot_base = impulses;
		apb_write(REG_CTRL, 32'h1);
		apb_read(REG_STATUS, status);
		while (status[STATUS_BUSY_BIT])
			apb_read(REG_STATUS, status);
	endtask

	task automatic check_result(input logic [31:0] d, input logic [31:0] status);
		check_reg(REG_STATUS, status, "status");
		check_reg(REG_DELAY, d, "delay");
		check_reg(REG_LAST_TWO, (d << 12) | d, "last_two");
		assert (done_irq) else begin
			reg_errs++;
			$display("ERR %0t: done_irq low after a result", $time);
		end
	endtask

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst_in = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (10) @(posedge clk_in);
		#2;
		rst_in = 1'b0;

		check_reg(REG_CTRL, 32'h0, "ctrl");
		check_reg(REG_HOLDOFF, 32'd4, "holdoff");
		check_reg(REG_STATUS, 32'h0, "status");
		check_reg(REG_DELAY, 32'h0, "delay");
		check_reg(REG_LAST_TWO, 32'h0, "last_two");
		check_reg(8'h14, 32'h0, "unmapped");
		apb_write(REG_HOLDOFF, 32'd6);
		check_reg(REG_HOLDOFF, 32'd6, "holdoff");

		// same echo on every shot
		echo_q = '{3 * WINDOW_LEN + 1, 3 * WINDOW_LEN + 1, 3 * WINDOW_LEN + 1};
		start_and_wait();
		check_result(expected_delay(3 * WINDOW_LEN + 1), 32'h2);

		// 64, 96, 96, 96
		echo_q = '{49, 81, 81, 81};
		start_and_wait();
		check_result(expected_delay(81), 32'h2);

		// a miss first and then three matches
		echo_q = '{NO_ECHO, 49, 49, 49};
		start_and_wait();
		check_result(expected_delay(49), 32'h102);

		// abort while listening
		echo_q = {};
		shot_base = impulses;
		apb_write(REG_CTRL, 32'h1);
		wait (impulses > shot_base);
		wait (samp_no >= 20);
		apb_write(REG_CTRL, 32'h0);
		check_reg(REG_STATUS, 32'h100, "status after abort");
		// longer than the rest of a shot plus hold-off and the next impulse
		repeat ((MAX_DELAY + 2 * WINDOW_LEN) * 4) begin
			@(negedge clk_in);
			assert (amp_out == '0 && !done_irq) else begin
				reg_errs++;
				$display("ERR %0t: output active after abort", $time);
			end
		end

		$display("errors: registers %0d, impulse shape %0d, idle amp %0d, bus %0d",
			reg_errs, shape_errs, amp_errs, bus_errs);
		if (reg_errs + shape_errs + amp_errs + bus_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/sonar_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sonar_top (
	input logic clk_in,
	input logic rst_in,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [sonar_regs_pkg::APB_AW-1:0] paddr,
	input logic [sonar_regs_pkg::APB_DW-1:0] pwdata,
	output logic [sonar_regs_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic step_in,
	input sonar_pkg::sample_t mic_in,
	output sonar_pkg::sample_t amp_out,
	output logic done_irq
);
	import sonar_pkg::*;

	logic run;
	logic [15:0] holdoff;
	logic busy;
	logic result_valid;
	delay_t delay;
	logic [23:0] last_two;
	logic timeout_pulse;
	logic fire;
	logic pulse_done;

	listen_if lis ();

	assign done_irq = result_valid;   // level, cleared by the next start

	apb_regs regs (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.holdoff(holdoff),
		.busy(busy),
		.result_valid(result_valid),
		.delay(delay),
		.last_two(last_two),
		.timeout_pulse(timeout_pulse)
	);

	sonar_ctrl ctrl (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.run(run),
		.holdoff(holdoff),
		.fire(fire),
		.pulse_done(pulse_done),
		.lis(lis.ctrl),
		.busy(busy),
		.result_valid(result_valid),
		.delay(delay),
		.last_two(last_two),
		.timeout_pulse(timeout_pulse)
	);

	// speaker side stops as soon as run is cleared
	impulse_gen imp (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.fire(fire),
		.abort(!run),
		.amp_out(amp_out),
		.pulse_done(pulse_done)
	);

	energy_window win (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.mic_in(mic_in),
		.lis(lis.window)
	);

	transient_detector det (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.lis(lis.detect)
	);

endmodule

`default_nettype wire

/* verilog/apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
	input logic clk_in,
	input logic rst_in,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [sonar_regs_pkg::APB_AW-1:0] paddr,
	input logic [sonar_regs_pkg::APB_DW-1:0] pwdata,
	output logic [sonar_regs_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic [15:0] holdoff,
	input logic busy,
	input logic result_valid,
	input sonar_pkg::delay_t delay,
	input logic [23:0] last_two,
	input logic timeout_pulse
);
	import sonar_regs_pkg::*;

	logic wr_en;
	logic rv_q;
	logic [STATUS_TO_W-1:0] to_cnt;   // saturating timeout count

	assign pready = 1'b1;    // no wait states
	assign pslverr = 1'b0;
	assign wr_en = psel && penable && pwrite;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			run <= 1'b0;
			holdoff <= HOLDOFF_RESET;
			to_cnt <= '0;
			rv_q <= 1'b0;
		end else begin
			rv_q <= result_valid;
			if (wr_en && paddr == REG_CTRL)
				run <= pwdata[CTRL_RUN_BIT];
			else if (result_valid && !rv_q)
				run <= 1'b0;   // run drops once a distance is confirmed
			if (wr_en && paddr == REG_HOLDOFF)
				holdoff <= pwdata[15:0];
			if (timeout_pulse && to_cnt != '1)
				to_cnt <= to_cnt + 1'b1;
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			REG_CTRL: prdata[CTRL_RUN_BIT] = run;
			REG_HOLDOFF: prdata = APB_DW'(holdoff);
			REG_STATUS: begin
				prdata[STATUS_BUSY_BIT] = busy;
				prdata[STATUS_VALID_BIT] = result_valid;
				prdata[STATUS_TO_LSB +: STATUS_TO_W] = to_cnt;
			end
			REG_DELAY: prdata = APB_DW'(delay);
			REG_LAST_TWO: prdata = APB_DW'(last_two);
			default: prdata = '0;   // unmapped
		endcase
	end

endmodule

`default_nettype wire

/* verilog/sonar_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module sonar_ctrl (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic run,
	input logic [15:0] holdoff,
	output logic fire,
	input logic pulse_done,
	listen_if.ctrl lis,
	output logic busy,
	output logic result_valid,
	output sonar_pkg::delay_t delay,
	output logic [23:0] last_two,
	output logic timeout_pulse
);
	import sonar_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_FIRE, S_AWAIT, S_LISTEN, S_HOLD} state_t;

	state_t state;
	logic run_q;
	logic [15:0] hold_cnt;          // hold-off steps so far
	delay_t hist [AGREE_COUNT-1];   // older onsets, newest at 0, zero when empty
	logic agree;
	logic timed_out;

	assign fire = (state == S_FIRE);
	assign lis.arm = (state == S_AWAIT) && pulse_done;   // sample 1 is the next step
	assign busy = (state != S_IDLE);

	// checked on the step after MAX_DELAY so the last window's onset can still land
	assign timed_out = step_in && (lis.sample_index >= delay_t'(MAX_DELAY));

	// new onset plus the whole history must match
	always_comb begin
		agree = 1'b1;
		for (int i = 0; i < AGREE_COUNT - 1; i++) begin
			if (hist[i] != lis.onset_index)
				agree = 1'b0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= S_IDLE;
			run_q <= 1'b0;
			hold_cnt <= '0;
			result_valid <= 1'b0;
			delay <= '0;
			last_two <= '0;
			timeout_pulse <= 1'b0;
			for (int i = 0; i < AGREE_COUNT - 1; i++)
				hist[i] <= '0;
		end else begin
			run_q <= run;
			timeout_pulse <= 1'b0;
			if (!run && state != S_IDLE) begin
				state <= S_IDLE;   // abort
			end else begin
				case (state)
					S_IDLE: if (run && !run_q) begin
						result_valid <= 1'b0;
						for (int i = 0; i < AGREE_COUNT - 1; i++)
							hist[i] <= '0;
						state <= S_FIRE;
					end
					S_FIRE: state <= S_AWAIT;
					S_AWAIT: if (pulse_done)
						state <= S_LISTEN;
					S_LISTEN: if (lis.onset) begin
						hist[0] <= lis.onset_index;
						for (int i = 1; i < AGREE_COUNT - 1; i++)
							hist[i] <= hist[i-1];
						hold_cnt <= '0;
						if (agree) begin
							delay <= lis.onset_index;
							last_two <= {hist[0], hist[1]};
							result_valid <= 1'b1;
							state <= S_IDLE;
						end else begin
							state <= S_HOLD;
						end
					end else if (timed_out) begin
						timeout_pulse <= 1'b1;
						for (int i = 0; i < AGREE_COUNT - 1; i++)
							hist[i] <= '0;   // a miss breaks the run of matches
						hold_cnt <= '0;
						state <= S_HOLD;
					end
					S_HOLD: if (hold_cnt == holdoff)
						state <= S_FIRE;
					else if (step_in)
						hold_cnt <= hold_cnt + 1'b1;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/transient_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module transient_detector (
	input logic clk_in,
	input logic rst_in,
	listen_if.detect lis
);
	import sonar_pkg::*;

	localparam int EW = $bits(energy_t);

	energy_t prev_e;    // previous window
	energy_t prev2_e;   // the one before that
	logic [EW:0] cur;
	logic [EW:0] dbl_prev;
	logic [EW:0] dbl_prev2;
	logic is_onset;

	// one extra bit so doubling never overflows
	assign cur = {1'b0, lis.window_energy};
	assign dbl_prev = {prev_e, 1'b0};
	assign dbl_prev2 = {prev2_e, 1'b0};
	assign is_onset = (cur > dbl_prev) && (cur > dbl_prev2);

	always_ff @(posedge clk_in) begin
		if (rst_in || lis.arm) begin
			// all ones masks the first two windows after arm
			prev_e <= '1;
			prev2_e <= '1;
			lis.onset <= 1'b0;
			lis.onset_index <= '0;
		end else begin
			lis.onset <= 1'b0;
			if (lis.window_valid) begin
				lis.onset <= is_onset;
				lis.onset_index <= lis.sample_index;
				prev2_e <= prev_e;
				prev_e <= lis.window_energy;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/energy_window.sv */
`timescale 1ns/1ns
`default_nettype none

module energy_window (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input sonar_pkg::sample_t mic_in,
	listen_if.window lis
);
	import sonar_pkg::*;

	localparam int CNT_W = $clog2(WINDOW_LEN);

	logic [CNT_W-1:0] win_cnt;   // position inside the current window
	energy_t acc;
	logic [15:0] mag;

	// -32768 negates to 0x8000, still right as an unsigned magnitude
	assign mag = mic_in[15] ? -mic_in : mic_in;

	always_ff @(posedge clk_in) begin
		if (rst_in || lis.arm) begin
			acc <= '0;
			win_cnt <= '0;
			lis.sample_index <= '0;
			lis.window_valid <= 1'b0;
			lis.window_energy <= '0;
		end else begin
			lis.window_valid <= 1'b0;
			if (step_in) begin
				lis.sample_index <= lis.sample_index + 1'b1;
				if (win_cnt == CNT_W'(WINDOW_LEN - 1)) begin
					// window closes on this step, publish and restart
					lis.window_energy <= acc + energy_t'(mag);
					lis.window_valid <= 1'b1;
					acc <= '0;
					win_cnt <= '0;
				end else begin
					acc <= acc + energy_t'(mag);
					win_cnt <= win_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/impulse_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module impulse_gen (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic fire,
	input logic abort,
	output sonar_pkg::sample_t amp_out,
	output logic pulse_done
);
	import sonar_pkg::*;

	localparam int CNT_W = $clog2(PULSE_LEN);
	localparam int HALF = PULSE_LEN / 2;

	logic active;
	logic [CNT_W-1:0] step_cnt;   // steps already sent

	// last sample of the impulse is consumed on this step
	assign pulse_done = active && step_in && (step_cnt == CNT_W'(PULSE_LEN - 1));

	always_comb begin
		if (!active)
			amp_out = '0;
		else if (step_cnt < CNT_W'(HALF))
			amp_out = PULSE_AMP;
		else
			amp_out = -PULSE_AMP;   // negative half
	end

	always_ff @(posedge clk_in) begin
		if (rst_in || abort) begin
			active <= 1'b0;
			step_cnt <= '0;
		end else if (fire) begin
			active <= 1'b1;
			step_cnt <= '0;
		end else if (pulse_done) begin
			active <= 1'b0;   // back to silence after the last step
		end else if (active && step_in) begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/listen_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface listen_if;
	import sonar_pkg::*;

	logic arm;               // clears window and detector state
	logic window_valid;
	energy_t window_energy;
	delay_t sample_index;    // samples since arm, current step included
	logic onset;
	delay_t onset_index;

	modport window (input arm, output window_valid, window_energy, sample_index);
	modport detect (input arm, window_valid, window_energy, sample_index,
		output onset, onset_index);
	modport ctrl (output arm, input sample_index, onset, onset_index);

endinterface

`default_nettype wire

/* verilog/sonar_regs_pkg.sv */
`default_nettype none

package sonar_regs_pkg;

	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// register offsets
	localparam logic [APB_AW-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_AW-1:0] REG_HOLDOFF = 8'h04;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;
	localparam logic [APB_AW-1:0] REG_DELAY = 8'h0C;
	localparam logic [APB_AW-1:0] REG_LAST_TWO = 8'h10;

	localparam int CTRL_RUN_BIT = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_VALID_BIT = 1;
	localparam int STATUS_TO_LSB = 8;           // timeout count field
	localparam int STATUS_TO_W = 8;
	localparam logic [15:0] HOLDOFF_RESET = 16'd4;   // steps between shots

endpackage

`default_nettype wire

/* verilog/sonar_pkg.sv */
`default_nettype none

package sonar_pkg;

	typedef logic signed [15:0] sample_t;   // mic and speaker samples
	typedef logic [31:0] energy_t;          // sum of |mic| over one window
	typedef logic [11:0] delay_t;           // counted in sample steps

	// energy window length, keep it a power of two
	localparam int WINDOW_LEN = 16;

	// listening limit per shot, a multiple of WINDOW_LEN
	localparam int MAX_DELAY = 512;

	localparam int PULSE_LEN = 8;                  // impulse length in samples
	localparam sample_t PULSE_AMP = 16'sd12000;    // positive half, second half negated

	// matching onsets needed before a distance is reported
	localparam int AGREE_COUNT = 3;

endpackage

`default_nettype wire
